/* src/mem_system_config.svh */
`ifndef MEM_SYSTEM_CONFIG_SVH
`define MEM_SYSTEM_CONFIG_SVH

// Address split: tag | index | byte offset
`define MS_ADDR_W    16
`define MS_DATA_W    16
`define MS_TAG_W     5
`define MS_INDEX_W   8
`define MS_OFFSET_W  3

// Banked memory timing, in clock cycles
`define MS_MEM_LAT   2
`define MS_BANK_BUSY 4

`endif

/* src/mem_system_pkg.sv */
`include "mem_system_config.svh"

package mem_system_pkg;

   // Widths with a meaning
   typedef logic [`MS_ADDR_W-1:0]   addr_t;
   typedef logic [`MS_DATA_W-1:0]   word_t;
   typedef logic [`MS_TAG_W-1:0]    tag_t;
   typedef logic [`MS_INDEX_W-1:0]  index_t;
   typedef logic [`MS_OFFSET_W-1:0] offset_t;

   // Controller states, read path and write path
   typedef enum logic [3:0] {
      st_idle         = 4'b0000,
      st_rd_compare   = 4'b0001,
      st_rd_writeback = 4'b0101,
      st_rd_fill      = 4'b0110,
      st_rd_return    = 4'b0111,
      st_wr_compare   = 4'b0100,
      st_wr_writeback = 4'b1001,
      st_wr_fill      = 4'b1010,
      st_wr_return    = 4'b1011
   } ctrl_state_t;

endpackage

/* src/cache_way.sv */
`timescale 1ns/1ps

module cache_way (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    enable,
   input  logic                    comp,
   input  logic                    write,
   input  logic                    valid_in,
   input  mem_system_pkg::tag_t    tag_in,
   input  mem_system_pkg::index_t  index,
   input  mem_system_pkg::offset_t offset,
   input  mem_system_pkg::word_t   data_in,
   output logic                    hit,
   output logic                    dirty,
   output logic                    valid,
   output mem_system_pkg::tag_t    tag_out,
   output mem_system_pkg::word_t   data_out
);
   import mem_system_pkg::*;

   localparam int NUM_LINES  = 1 << $bits(index_t);
   localparam int WORD_SEL_W = $bits(index_t) + 2;

   // Per-line state
   tag_t                 tag_mem  [NUM_LINES];
   word_t                data_mem [NUM_LINES*4];
   logic [NUM_LINES-1:0] valid_bits;
   logic [NUM_LINES-1:0] dirty_bits;

   logic [WORD_SEL_W-1:0] word_sel;
   logic                  tag_match;
   logic                  wr_compare;
   logic                  wr_access;

   // Word within line from offset bits 2:1
   assign word_sel  = {index, offset[2:1]};
   assign tag_match = (tag_mem[index] == tag_in);

   // Combinational read side
   assign valid    = valid_bits[index];
   assign dirty    = dirty_bits[index];
   assign tag_out  = tag_mem[index];
   assign data_out = data_mem[word_sel];
   // Hit only meaningful in compare mode
   assign hit      = comp & valid & tag_match;

   // Compare write lands only on a hit
   assign wr_compare = enable & write & comp & hit;
   // Access write used by line fill
   assign wr_access  = enable & write & ~comp;

   //////////////////////////////
   // Tag and data arrays
   always_ff @(posedge clk) begin
      if (wr_access) begin
         tag_mem[index] <= tag_in;
      end
      if (wr_compare | wr_access) begin
         data_mem[word_sel] <= data_in;
      end
   end

   //////////////////////////////
   // Valid and dirty bits
   always_ff @(posedge clk) begin
      if (reset) begin
         valid_bits <= '0;
         dirty_bits <= '0;
      end else if (wr_access) begin
         // Freshly filled line starts clean
         valid_bits[index] <= valid_in;
         dirty_bits[index] <= 1'b0;
      end else if (wr_compare) begin
         dirty_bits[index] <= 1'b1;
      end
   end

endmodule

/* src/four_bank_mem.sv */
`timescale 1ns/1ps
`include "mem_system_config.svh"

module four_bank_mem (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  wr,
   input  logic                  rd,
   input  mem_system_pkg::addr_t addr,
   input  mem_system_pkg::word_t data_in,
   output mem_system_pkg::word_t data_out,
   output logic                  stall,
   output logic [3:0]            busy
);
   import mem_system_pkg::*;

   localparam int NUM_WORDS = 1 << ($bits(addr_t) - 1);
   localparam int BUSY_W    = $clog2(`MS_BANK_BUSY) + 1;

   // Word storage, cleared at time zero only
   word_t mem [NUM_WORDS] = '{default: '0};

   logic [BUSY_W-1:0]        busy_cnt [4];
   logic [$bits(addr_t)-2:0] word_addr;
   logic [1:0]               bank;
   logic                     accept;

   // Read pipeline, one slot per cycle of latency
   word_t                  rd_data_pipe [`MS_MEM_LAT];
   logic [`MS_MEM_LAT-1:0] rd_valid_pipe;

   assign word_addr = addr[$bits(addr_t)-1:1];
   // Banks interleaved on word address
   assign bank      = addr[2:1];

   always_comb begin
      for (int b = 0; b < 4; b++) begin
         busy[b] = (busy_cnt[b] != '0);
      end
   end

   // Strobe to a busy bank is held off
   assign stall  = (wr | rd) & busy[bank];
   assign accept = (wr | rd) & ~stall;

   //////////////////////////////
   // Bank busy down-counters
   always_ff @(posedge clk) begin
      for (int b = 0; b < 4; b++) begin
         if (reset) begin
            busy_cnt[b] <= '0;
         end else if (accept && (bank == 2'(b))) begin
            busy_cnt[b] <= BUSY_W'(`MS_BANK_BUSY - 1);
         end else if (busy_cnt[b] != '0) begin
            busy_cnt[b] <= busy_cnt[b] - 1'b1;
         end
      end
   end

   // Storage write
   always_ff @(posedge clk) begin
      if (accept & wr) begin
         mem[word_addr] <= data_in;
      end
   end

   //////////////////////////////
   // Read data path
   always_ff @(posedge clk) begin
      rd_data_pipe[0] <= mem[word_addr];
      for (int s = 1; s < `MS_MEM_LAT; s++) begin
         rd_data_pipe[s] <= rd_data_pipe[s-1];
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_valid_pipe <= '0;
      end else begin
         rd_valid_pipe[0] <= accept & rd;
         for (int s = 1; s < `MS_MEM_LAT; s++) begin
            rd_valid_pipe[s] <= rd_valid_pipe[s-1];
         end
      end
   end

   // Data valid for a single cycle
   assign data_out = rd_valid_pipe[`MS_MEM_LAT-1] ? rd_data_pipe[`MS_MEM_LAT-1] : '0;

endmodule

/* src/cache_ctrl.sv */
`timescale 1ns/1ps
`include "mem_system_config.svh"

module cache_ctrl (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    rd,
   input  logic                    wr,
   input  mem_system_pkg::addr_t   addr,
   input  mem_system_pkg::word_t   data_in,
   output mem_system_pkg::word_t   data_out,
   output logic                    done,
   output logic                    stall,
   output logic                    cache_hit,
   output logic                    err,
   input  logic                    c0_hit,
   input  logic                    c0_dirty,
   input  logic                    c0_valid,
   input  mem_system_pkg::tag_t    c0_tag_out,
   input  mem_system_pkg::word_t   c0_data_out,
   input  logic                    c1_hit,
   input  logic                    c1_dirty,
   input  logic                    c1_valid,
   input  mem_system_pkg::tag_t    c1_tag_out,
   input  mem_system_pkg::word_t   c1_data_out,
   output logic                    c0_enable,
   output logic                    c1_enable,
   output logic                    comp,
   output logic                    cache_write,
   output logic                    valid_in,
   output mem_system_pkg::tag_t    cache_tag,
   output mem_system_pkg::index_t  cache_index,
   output mem_system_pkg::offset_t cache_offset,
   output mem_system_pkg::word_t   cache_data_in,
   input  logic                    mem_stall,
   input  mem_system_pkg::word_t   mem_data_out,
   output logic                    mem_wr,
   output logic                    mem_rd,
   output mem_system_pkg::addr_t   mem_addr,
   output mem_system_pkg::word_t   mem_data_in
);
   import mem_system_pkg::*;

   localparam int LAT = `MS_MEM_LAT;

   ctrl_state_t state, next_state;

   // Captured request
   addr_t   req_addr;
   word_t   req_data;
   tag_t    req_tag;
   index_t  req_index;
   offset_t req_offset;

   logic [2:0]     line_cnt;
   logic           cnt_inc, cnt_clr;
   logic           victim, sel_way, sel_now, sel_dirty;
   logic           any_hit, is_compare, capture, strobe_ok, last_word;
   word_t          hit_data, sel_data;
   tag_t           sel_tag;
   logic [LAT-1:0] ret_valid;
   logic [1:0]     ret_word [LAT];

   assign {req_tag, req_index, req_offset} = req_addr;

   // Odd address or both strobes
   assign err       = (rd & wr) | ((rd | wr) & addr[0]);
   // Flagged strobes are dropped
   assign strobe_ok = (rd | wr) & ~err;
   assign capture   = (state == st_idle) & strobe_ok;
   assign is_compare = (state == st_rd_compare) | (state == st_wr_compare);

   // Hit merge
   assign any_hit  = c0_hit | c1_hit;
   assign hit_data = c1_hit ? c1_data_out : c0_data_out;

   // First invalid way, else the victim bit
   assign sel_now   = ~c0_valid ? 1'b0 : (~c1_valid ? 1'b1 : victim);
   assign sel_dirty = sel_now ? (c1_valid & c1_dirty) : (c0_valid & c0_dirty);
   assign sel_data  = sel_way ? c1_data_out : c0_data_out;
   assign sel_tag   = sel_way ? c1_tag_out : c0_tag_out;

   // Last fill word coming back from memory
   assign last_word = ret_valid[LAT-1] & (ret_word[LAT-1] == 2'd3);

   always_ff @(posedge clk) begin
      if (capture) begin
         req_addr <= addr;
         req_data <= data_in;
      end
      ret_word[0] <= line_cnt[1:0];
      for (int s = 1; s < LAT; s++) begin
         ret_word[s] <= ret_word[s-1];
      end
   end

   //////////////////////////////
   // Control registers
   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= st_idle;
         victim    <= 1'b0;
         sel_way   <= 1'b0;
         line_cnt  <= '0;
         ret_valid <= '0;
      end else begin
         state <= next_state;
         // Victim flips on every compare
         if (is_compare) begin
            victim  <= ~victim;
            sel_way <= sel_now;
         end
         if (cnt_clr) begin
            line_cnt <= '0;
         end else if (cnt_inc) begin
            line_cnt <= line_cnt + 1'b1;
         end
         // Track fill reads in flight
         ret_valid[0] <= mem_rd & ~mem_stall;
         for (int s = 1; s < LAT; s++) begin
            ret_valid[s] <= ret_valid[s-1];
         end
      end
   end

   //////////////////////////////
   // Next state and outputs
   always_comb begin
      next_state    = state;
      stall         = 1'b1;
      done          = 1'b0;
      cache_hit     = 1'b0;
      data_out      = '0;
      c0_enable     = 1'b0;
      c1_enable     = 1'b0;
      comp          = 1'b0;
      cache_write   = 1'b0;
      valid_in      = 1'b0;
      cache_tag     = req_tag;
      cache_index   = req_index;
      cache_offset  = req_offset;
      cache_data_in = req_data;
      mem_wr        = 1'b0;
      mem_rd        = 1'b0;
      mem_addr      = {req_tag, req_index, line_cnt[1:0], 1'b0};
      mem_data_in   = sel_data;
      cnt_inc       = 1'b0;
      cnt_clr       = 1'b0;

      case (state)
         st_idle: begin
            stall   = 1'b0;
            cnt_clr = 1'b1;
            if (strobe_ok) begin
               next_state = rd ? st_rd_compare : st_wr_compare;
            end
         end

         st_rd_compare, st_wr_compare: begin
            comp        = 1'b1;
            cache_write = (state == st_wr_compare);
            c0_enable   = 1'b1;
            c1_enable   = 1'b1;
            done        = any_hit;
            cache_hit   = any_hit;
            data_out    = hit_data;
            if (any_hit) begin
               next_state = st_idle;
            end else if (state == st_rd_compare) begin
               next_state = sel_dirty ? st_rd_writeback : st_rd_fill;
            end else begin
               next_state = sel_dirty ? st_wr_writeback : st_wr_fill;
            end
         end

         // Dirty victim line out, one word per accepted write
         st_rd_writeback, st_wr_writeback: begin
            c0_enable    = ~sel_way;
            c1_enable    = sel_way;
            cache_offset = {line_cnt[1:0], 1'b0};
            mem_wr       = 1'b1;
            mem_addr     = {sel_tag, req_index, line_cnt[1:0], 1'b0};
            if (~mem_stall) begin
               if (line_cnt == 3'd3) begin
                  cnt_clr    = 1'b1;
                  next_state = (state == st_rd_writeback) ? st_rd_fill : st_wr_fill;
               end else begin
                  cnt_inc = 1'b1;
               end
            end
         end

         // Issue four reads, write words as they return
         st_rd_fill, st_wr_fill: begin
            mem_rd        = ~line_cnt[2];
            cnt_inc       = mem_rd & ~mem_stall;
            cache_write   = 1'b1;
            valid_in      = 1'b1;
            cache_offset  = {ret_word[LAT-1], 1'b0};
            cache_data_in = mem_data_out;
            c0_enable     = ret_valid[LAT-1] & ~sel_way;
            c1_enable     = ret_valid[LAT-1] & sel_way;
            if (last_word) begin
               next_state = (state == st_rd_fill) ? st_rd_return : st_wr_return;
            end
         end

         st_rd_return: begin
            comp       = 1'b1;
            c0_enable  = ~sel_way;
            c1_enable  = sel_way;
            done       = 1'b1;
            data_out   = sel_data;
            next_state = st_idle;
         end

         // Compare write on the new line marks it dirty
         st_wr_return: begin
            comp        = 1'b1;
            cache_write = 1'b1;
            c0_enable   = ~sel_way;
            c1_enable   = sel_way;
            done        = 1'b1;
            next_state  = st_idle;
         end

         default: next_state = st_idle;
      endcase
   end

endmodule

/* src/mem_system.sv */
`timescale 1ns/1ps

module mem_system (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  Rd,
   input  logic                  Wr,
   input  mem_system_pkg::addr_t Addr,
   input  mem_system_pkg::word_t DataIn,
   output mem_system_pkg::word_t DataOut,
   output logic                  Done,
   output logic                  Stall,
   output logic                  CacheHit,
   output logic                  err
);
   import mem_system_pkg::*;

   // Shared cache way inputs
   logic    c0_enable, c1_enable, comp, cache_write, valid_in;
   tag_t    cache_tag;
   index_t  cache_index;
   offset_t cache_offset;
   word_t   cache_data_in;

   // Way status
   logic    c0_hit, c0_dirty, c0_valid;
   logic    c1_hit, c1_dirty, c1_valid;
   tag_t    c0_tag_out, c1_tag_out;
   word_t   c0_data_out, c1_data_out;

   // Memory side
   logic    mem_wr, mem_rd, mem_stall;
   addr_t   mem_addr;
   word_t   mem_data_in, mem_data_out;

   cache_ctrl ctrl (
      .clk(clk), .reset(reset), .rd(Rd), .wr(Wr), .addr(Addr), .data_in(DataIn),
      .data_out(DataOut), .done(Done), .stall(Stall), .cache_hit(CacheHit), .err(err),
      .c0_hit(c0_hit), .c0_dirty(c0_dirty), .c0_valid(c0_valid),
      .c0_tag_out(c0_tag_out), .c0_data_out(c0_data_out),
      .c1_hit(c1_hit), .c1_dirty(c1_dirty), .c1_valid(c1_valid),
      .c1_tag_out(c1_tag_out), .c1_data_out(c1_data_out),
      .c0_enable(c0_enable), .c1_enable(c1_enable), .comp(comp),
      .cache_write(cache_write), .valid_in(valid_in), .cache_tag(cache_tag),
      .cache_index(cache_index), .cache_offset(cache_offset), .cache_data_in(cache_data_in),
      .mem_stall(mem_stall), .mem_data_out(mem_data_out), .mem_wr(mem_wr),
      .mem_rd(mem_rd), .mem_addr(mem_addr), .mem_data_in(mem_data_in)
   );

   cache_way way0 (
      .clk(clk), .reset(reset), .enable(c0_enable), .comp(comp), .write(cache_write),
      .valid_in(valid_in), .tag_in(cache_tag), .index(cache_index), .offset(cache_offset),
      .data_in(cache_data_in), .hit(c0_hit), .dirty(c0_dirty), .valid(c0_valid),
      .tag_out(c0_tag_out), .data_out(c0_data_out)
   );

   cache_way way1 (
      .clk(clk), .reset(reset), .enable(c1_enable), .comp(comp), .write(cache_write),
      .valid_in(valid_in), .tag_in(cache_tag), .index(cache_index), .offset(cache_offset),
      .data_in(cache_data_in), .hit(c1_hit), .dirty(c1_dirty), .valid(c1_valid),
      .tag_out(c1_tag_out), .data_out(c1_data_out)
   );

   // Bank busy flags visible for debug only
   four_bank_mem mem (
      .clk(clk), .reset(reset), .wr(mem_wr), .rd(mem_rd), .addr(mem_addr),
      .data_in(mem_data_in), .data_out(mem_data_out), .stall(mem_stall), .busy()
   );

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
   output logic clk,
   output logic reset
);
   // 8 ns period
   localparam int HALF_PERIOD = 4;

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   // Reset held over two rising edges, released just after the second
   initial begin
      reset = 1'b1;
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;
   end

endmodule

/* tb/tb_mem_system.sv */
`timescale 1ns/1ps

module tb_mem_system;
   import mem_system_pkg::*;

   localparam int          CLK_PERIOD   = 8;
   localparam int          DRIVE_DELAY  = 1;
   localparam int          NUM_RANDOM   = 200;
   // Directed accesses plus the random mix
   localparam int          NUM_ACCESSES = 21 + NUM_RANDOM;
   localparam int          ACCESS_LIMIT = 40;
   localparam int          REF_WORDS    = 32768;
   localparam logic [31:0] LFSR_SEED    = 32'h899e468f;

   logic  clk;
   logic  reset;
   logic  Rd;
   logic  Wr;
   addr_t Addr;
   word_t DataIn;
   word_t DataOut;
   logic  Done;
   logic  Stall;
   logic  CacheHit;
   logic  err;

   // Reference memory, one entry per 16-bit word
   word_t       ref_mem [REF_WORDS];
   logic [31:0] lfsr_state;

   tb_clock_gen clock_gen (
      .clk(clk),
      .reset(reset)
   );

   mem_system UUT (
      .clk(clk), .reset(reset), .Rd(Rd), .Wr(Wr), .Addr(Addr), .DataIn(DataIn),
      .DataOut(DataOut), .Done(Done), .Stall(Stall), .CacheHit(CacheHit), .err(err)
   );

   //////////////////////////////
   // Failure reporting and checks
   task automatic abort_run();
      $display("Regression failed");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic check_equal(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected) else begin
         $display("FAIL time=%0t signal=%s expected=%0h actual=%0h",
                  $time, name, expected, actual);
         abort_run();
      end
   endtask

   //////////////////////////////
   // Galois LFSR, taps x^32+x^22+x^2+x+1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 32'h80200003;
      end
      return n;
   endfunction

   // One LFSR step per bit taken
   task automatic take_bits(input int count, output logic [31:0] val);
      val = '0;
      for (int k = 0; k < count; k++) begin
         val        = {val[30:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   // tag | index | word | 0
   function automatic addr_t make_addr(input tag_t tag, input index_t index,
                                       input logic [1:0] word);
      return {tag, index, word, 1'b0};
   endfunction

   //////////////////////////////
   // One request, from idle to Done
   task automatic do_access(input logic is_write, input addr_t addr, input word_t data,
                            input int expect_hit, output int latency);
      word_t expected;
      int    cycles;
      expected = ref_mem[addr[15:1]];
      @(negedge clk);
      while (Stall) begin
         @(negedge clk);
      end
      @(posedge clk);
      #DRIVE_DELAY;
      Rd     = ~is_write;
      Wr     = is_write;
      Addr   = addr;
      DataIn = data;
      // Aligned single strobe
      @(negedge clk);
      check_equal("err", 0, err);
      @(posedge clk);
      #DRIVE_DELAY;
      Rd     = 1'b0;
      Wr     = 1'b0;
      // Scramble inputs, the request is already captured
      Addr   = addr ^ 16'hfff0;
      DataIn = ~data;
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
         // Busy until the request is over
         check_equal("Stall", 1, Stall);
      end while (!Done);
      if (expect_hit >= 0) begin
         check_equal("CacheHit", expect_hit, CacheHit);
      end
      if (is_write) begin
         ref_mem[addr[15:1]] = data;
      end else begin
         check_equal("DataOut", expected, DataOut);
      end
      latency = cycles;
   endtask

   task automatic read_word(input addr_t addr, input int expect_hit);
      int lat;
      do_access(1'b0, addr, '0, expect_hit, lat);
   endtask

   task automatic write_word(input addr_t addr, input word_t data, input int expect_hit);
      int lat;
      do_access(1'b1, addr, data, expect_hit, lat);
   endtask

   //////////////////////////////
   // Directed tests
   task automatic reset_and_idle();
      @(negedge clk);
      check_equal("Done", 0, Done);
      check_equal("CacheHit", 0, CacheHit);
      check_equal("err", 0, err);
      check_equal("Stall", 0, Stall);
      // Untouched word reads as zero
      read_word(make_addr(5'h01, 8'h01, 2'd0), 0);
   endtask

   task automatic write_miss_read_hit();
      addr_t       addr;
      logic [31:0] r;
      int          lat;
      addr = make_addr(5'h03, 8'h02, 2'd1);
      take_bits(16, r);
      do_access(1'b1, addr, r[15:0], 0, lat);
      do_access(1'b0, addr, '0, 1, lat);
      // Hit answers in the cycle after the request edge
      check_equal("Done latency", 1, lat);
   endtask

   task automatic line_fill();
      logic [31:0] r;
      for (int w = 0; w < 4; w++) begin
         take_bits(16, r);
         write_word(make_addr(5'h06, 8'h03, w[1:0]), r[15:0], (w == 0) ? 0 : 1);
      end
      // Three more tags, last two misses land in opposite ways
      read_word(make_addr(5'h07, 8'h03, 2'd0), 0);
      read_word(make_addr(5'h08, 8'h03, 2'd0), 0);
      read_word(make_addr(5'h09, 8'h03, 2'd0), 0);
      // Line came back from memory on this miss
      read_word(make_addr(5'h06, 8'h03, 2'd2), 0);
      read_word(make_addr(5'h06, 8'h03, 2'd0), 1);
      read_word(make_addr(5'h06, 8'h03, 2'd1), 1);
      read_word(make_addr(5'h06, 8'h03, 2'd3), 1);
   endtask

   task automatic eviction_writeback();
      logic [31:0] r;
      for (int t = 0; t < 3; t++) begin
         take_bits(16, r);
         write_word(make_addr(5'h0a + t[4:0], 8'h04, 2'd0), r[15:0], 0);
      end
      // Hit status depends on the victim bit
      for (int t = 0; t < 3; t++) begin
         read_word(make_addr(5'h0a + t[4:0], 8'h04, 2'd0), -1);
      end
   endtask

   task automatic error_flag_check();
      @(posedge clk);
      #DRIVE_DELAY;
      Rd   = 1'b1;
      Addr = make_addr(5'h02, 8'h05, 2'd1) | 16'h0001;
      @(negedge clk);
      check_equal("err", 1, err);
      @(posedge clk);
      #DRIVE_DELAY;
      // Both strobes, aligned address
      Wr   = 1'b1;
      Addr = make_addr(5'h02, 8'h05, 2'd1);
      @(negedge clk);
      check_equal("err", 1, err);
      @(posedge clk);
      #DRIVE_DELAY;
      Rd = 1'b0;
      Wr = 1'b0;
      // Flagged strobes start nothing
      repeat (3) begin
         @(negedge clk);
         check_equal("Done", 0, Done);
         check_equal("Stall", 0, Stall);
      end
      read_word(make_addr(5'h02, 8'h05, 2'd1), 0);
   endtask

   task automatic random_mix();
      logic [31:0] op;
      logic [31:0] t;
      logic [31:0] ix;
      logic [31:0] w;
      logic [31:0] d;
      addr_t       addr;
      for (int n = 0; n < NUM_RANDOM; n++) begin
         take_bits(1, op);
         take_bits(2, t);
         take_bits(1, ix);
         take_bits(2, w);
         take_bits(16, d);
         // Four tags over two sets, more than the two ways hold
         addr = make_addr({3'b101, t[1:0]}, {7'h20, ix[0]}, w[1:0]);
         if (op[0]) begin
            write_word(addr, d[15:0], -1);
         end else begin
            read_word(addr, -1);
         end
      end
   endtask

   //////////////////////////////
   // Watchdog
   initial begin
      #((NUM_ACCESSES * ACCESS_LIMIT + 50) * CLK_PERIOD);
      $display("Timeout: the tests did not finish within the watchdog limit");
      abort_run();
   end

   // Main sequence
   initial begin
      Rd         = 1'b0;
      Wr         = 1'b0;
      Addr       = '0;
      DataIn     = '0;
      lfsr_state = LFSR_SEED;
      for (int i = 0; i < REF_WORDS; i++) begin
         ref_mem[i] = '0;
      end
      wait (reset === 1'b0);
      reset_and_idle();
      write_miss_read_hit();
      line_fill();
      eviction_writeback();
      error_flag_check();
      random_mix();
      $display("Regression passed");
      $finish;
   end

endmodule

/* sim.f */
+incdir+src
src/mem_system_pkg.sv
src/cache_way.sv
src/four_bank_mem.sv
src/cache_ctrl.sv
src/mem_system.sv
tb/tb_clock_gen.sv
tb/tb_mem_system.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, then look for the fail message in the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_system \
   -f sim.f -o tb_mem_system_sim || exit 1
./obj_dir/tb_mem_system_sim > sim.log 2>&1
cat sim.log
test -s sim.log && ! grep -q "Regression failed" sim.log && exit 0 || exit 1
